//--- codeword_sequencer.sv
// Codeword sequencer
// Steps through three codeword phases while the waveform runs and
// registers the TX sample word, the idle word when stopped

`timescale 1ns/10ps

module codeword_sequencer import radio_pkg::*; (
   input  logic              bus_clk,
   input  logic              i_rst_n,
   input  logic              i_run,
   input  logic              i_clr,
   input  logic [DATA_W-1:0] i_idle,
   input  logic [DATA_W-1:0] i_cw0,
   input  logic [15:0]       i_cw1,
   input  logic [15:0]       i_cw2,
   output logic [DATA_W-1:0] o_tx,
   output phase_t            o_phase
);

   localparam phase_t LAST_PHASE = 2'd2;

   logic [DATA_W-1:0] phase_word;

   //////////////////////////////
   // Phase word build
   //////////////////////////////
   always_comb begin
      case (o_phase)
         2'd0:    phase_word = i_cw0;
         2'd1:    phase_word = {i_cw1, i_cw2};   // cw1 on I, cw2 on Q
         2'd2:    phase_word = {i_cw2, i_cw1};   // Swapped
         default: phase_word = i_cw0;
      endcase
   end

   //////////////////////////////
   // Phase counter and TX register
   //////////////////////////////
   always_ff @(posedge bus_clk) begin
      if (!i_rst_n) begin
         o_phase <= '0;
         o_tx    <= '0;
      end else begin
         o_tx <= i_run ? phase_word : i_idle;

         if (!i_run || i_clr)
            o_phase <= '0;
         else if (o_phase == LAST_PHASE)
            o_phase <= '0;                    // Wrap
         else
            o_phase <= o_phase + 1'b1;
      end
   end

   // Readback status and word build both rely on a 3-state phase
   a_phase_legal: assert property (
      @(posedge bus_clk) disable iff (!i_rst_n)
      o_phase != 2'd3
   ) else $error("codeword_sequencer: phase reached illegal value 3");

endmodule

//--- radio_core.f
radio_pkg.sv
settings_regs.sv
timekeeper.sv
codeword_sequencer.sv
readback_mux.sv
radio_core.sv
tb_clkgen.sv
tb_checker.sv
tb_radio.sv

//--- radio_core.sv
// Radio slow-control core
// Setting registers, timekeeper, codeword sequencer and readback mux
// on the setting bus, all in the bus_clk domain

`timescale 1ns/10ps

module radio_core import radio_pkg::*; #(
   parameter int TIME_BASE = SR_TIME_DEFAULT
) (
   input  logic              bus_clk,
   input  logic              i_rst_n,
   input  logic              i_set_stb,
   input  logic [ADDR_W-1:0] i_set_addr,
   input  logic [DATA_W-1:0] i_set_data,
   input  logic [DATA_W-1:0] i_rx,
   input  logic              i_pps,
   output logic [DATA_W-1:0] o_tx,
   output rb_word_t          o_rb_data,
   output logic [TIME_W-1:0] o_vita_time
);

   logic [DATA_W-1:0]   test;
   logic [DATA_W-1:0]   idle;
   logic [DATA_W-1:0]   cw0;
   logic [15:0]         cw1;
   logic [15:0]         cw2;
   logic [RB_SEL_W-1:0] rb_sel;
   logic                run;
   logic                clr;
   logic [TIME_W-1:0]   lastpps;
   phase_t              phase;

   settings_regs u_settings_regs (
      .bus_clk    (bus_clk),    .i_rst_n    (i_rst_n),
      .i_set_stb  (i_set_stb),  .i_set_addr (i_set_addr), .i_set_data (i_set_data),
      .o_test     (test),       .o_idle     (idle),
      .o_cw0      (cw0),        .o_cw1      (cw1),        .o_cw2      (cw2),
      .o_rb_sel   (rb_sel),     .o_run      (run),        .o_clr      (clr)
   );

   timekeeper #(
      .TIME_BASE (TIME_BASE)
   ) u_timekeeper (
      .bus_clk     (bus_clk),    .i_rst_n    (i_rst_n),
      .i_set_stb   (i_set_stb),  .i_set_addr (i_set_addr), .i_set_data (i_set_data),
      .i_pps       (i_pps),
      .o_vita_time (o_vita_time),
      .o_lastpps   (lastpps)
   );

   codeword_sequencer u_codeword_sequencer (
      .bus_clk (bus_clk), .i_rst_n (i_rst_n),
      .i_run   (run),     .i_clr   (clr),     .i_idle (idle),
      .i_cw0   (cw0),     .i_cw1   (cw1),     .i_cw2  (cw2),
      .o_tx    (o_tx),    .o_phase (phase)
   );

   readback_mux u_readback_mux (
      .bus_clk     (bus_clk),     .i_rst_n   (i_rst_n),
      .i_rb_sel    (rb_sel),      .i_test    (test),
      .i_vita_time (o_vita_time), .i_lastpps (lastpps),
      .i_tx        (o_tx),        .i_rx      (i_rx),
      .i_run       (run),         .i_phase   (phase),
      .o_rb_data   (o_rb_data)
   );

endmodule

//--- radio_pkg.sv
// Radio slow-control package
// Setting bus addresses, field widths, readback selects and the
// readback word type shared by the radio control blocks

package radio_pkg;

   //////////////////////////////
   // Widths
   //////////////////////////////
   localparam int ADDR_W   = 8;
   localparam int DATA_W   = 32;              // Setting data, TX and RX words
   localparam int TIME_W   = 64;
   localparam int RB_SEL_W = 3;

   //////////////////////////////
   // Setting bus addresses
   //////////////////////////////
   localparam logic [ADDR_W-1:0] SR_TEST       = 8'd21;
   localparam logic [ADDR_W-1:0] SR_CODEC_IDLE = 8'd22;
   localparam logic [ADDR_W-1:0] SR_READBACK   = 8'd32;
   localparam logic [ADDR_W-1:0] SR_CNTRL      = 8'd163;
   localparam logic [ADDR_W-1:0] SR_LLR_REG0   = 8'd164;
   localparam logic [ADDR_W-1:0] SR_LLR_REG1   = 8'd165;
   localparam logic [ADDR_W-1:0] SR_LLR_REG2   = 8'd166;

   // Time registers: base is high word, base+1 low word, base+2 control
   localparam int SR_TIME_DEFAULT = 128;

   // Control register fields
   localparam int CNTRL_CLR_BIT = 0;          // Restart sequencer phase
   localparam int CNTRL_RUN_BIT = 1;          // Waveform running

   // Time control fields
   localparam int TIME_LOAD_NOW_BIT = 0;
   localparam int TIME_LOAD_PPS_BIT = 1;

   //////////////////////////////
   // Readback selects
   //////////////////////////////
   localparam logic [RB_SEL_W-1:0] RB_TEST    = 3'd0;
   localparam logic [RB_SEL_W-1:0] RB_TIME    = 3'd1;
   localparam logic [RB_SEL_W-1:0] RB_LASTPPS = 3'd2;
   localparam logic [RB_SEL_W-1:0] RB_TXRX    = 3'd3;
   localparam logic [RB_SEL_W-1:0] RB_STATUS  = 3'd4;

   // Readback word, either one time value or two 32-bit halves (1 is high)
   typedef union packed {
      logic [TIME_W-1:0]           time_val;
      logic [1:0][DATA_W-1:0]      half;
   } rb_word_t;

   typedef logic [1:0] phase_t;               // Sequencer phase, 0 to 2

endpackage

//--- readback_mux.sv
// Readback multiplexer
// Registered selection of the 64-bit readback word, one cycle latency

`timescale 1ns/10ps

module readback_mux import radio_pkg::*; (
   input  logic                bus_clk,
   input  logic                i_rst_n,
   input  logic [RB_SEL_W-1:0] i_rb_sel,
   input  logic [DATA_W-1:0]   i_test,
   input  logic [TIME_W-1:0]   i_vita_time,
   input  logic [TIME_W-1:0]   i_lastpps,
   input  logic [DATA_W-1:0]   i_tx,
   input  logic [DATA_W-1:0]   i_rx,
   input  logic                i_run,
   input  phase_t              i_phase,
   output rb_word_t            o_rb_data
);

   rb_word_t rb_nxt;

   always_comb begin
      rb_nxt = '0;                           // Unused selects read zero
      case (i_rb_sel)
         RB_TEST: begin
            rb_nxt.half[0] = i_test;
         end
         RB_TIME: begin
            rb_nxt.time_val = i_vita_time;
         end
         RB_LASTPPS: begin
            rb_nxt.time_val = i_lastpps;
         end
         RB_TXRX: begin
            rb_nxt.half[1] = i_tx;
            rb_nxt.half[0] = i_rx;
         end
         RB_STATUS: begin
            // Run flag above the 2-bit phase
            rb_nxt.half[0][2]   = i_run;
            rb_nxt.half[0][1:0] = i_phase;
         end
         default: begin
            rb_nxt = '0;
         end
      endcase
   end

   always_ff @(posedge bus_clk) begin
      if (!i_rst_n)
         o_rb_data <= '0;
      else
         o_rb_data <= rb_nxt;
   end

endmodule

//--- settings_regs.sv
// Radio setting registers
// Decodes setting bus writes into the test, codec idle, readback select,
// control and codeword registers

`timescale 1ns/10ps

module settings_regs import radio_pkg::*; (
   input  logic                bus_clk,
   input  logic                i_rst_n,
   // Setting bus
   input  logic                i_set_stb,
   input  logic [ADDR_W-1:0]   i_set_addr,
   input  logic [DATA_W-1:0]   i_set_data,
   // Register outputs
   output logic [DATA_W-1:0]   o_test,
   output logic [DATA_W-1:0]   o_idle,
   output logic [DATA_W-1:0]   o_cw0,
   output logic [15:0]         o_cw1,
   output logic [15:0]         o_cw2,
   output logic [RB_SEL_W-1:0] o_rb_sel,
   output logic                o_run,
   output logic                o_clr
);

   //////////////////////////////
   // Register file
   //////////////////////////////
   always_ff @(posedge bus_clk) begin
      if (!i_rst_n) begin
         o_test   <= '0;
         o_idle   <= '0;
         o_cw0    <= '0;
         o_cw1    <= '0;
         o_cw2    <= '0;
         o_rb_sel <= '0;
         o_run    <= 1'b0;
         o_clr    <= 1'b0;
      end else if (i_set_stb) begin
         case (i_set_addr)
            SR_TEST: begin
               o_test <= i_set_data;
            end
            SR_CODEC_IDLE: begin
               o_idle <= i_set_data;             // Sent on TX while stopped
            end
            SR_READBACK: begin
               o_rb_sel <= i_set_data[RB_SEL_W-1:0];
            end
            SR_CNTRL: begin
               // Only run and clear are kept
               o_run <= i_set_data[CNTRL_RUN_BIT];
               o_clr <= i_set_data[CNTRL_CLR_BIT];
            end
            SR_LLR_REG0: begin
               o_cw0 <= i_set_data;
            end
            SR_LLR_REG1: begin
               o_cw1 <= i_set_data[15:0];        // Lower half only
            end
            SR_LLR_REG2: begin
               o_cw2 <= i_set_data[15:0];
            end
            default: begin
               // Addresses owned by other blocks
            end
         endcase
      end
   end

   //////////////////////////////
   // Checks
   //////////////////////////////

   // Readback mux decodes this select every cycle
   a_rb_sel_known: assert property (
      @(posedge bus_clk) disable iff (!i_rst_n)
      !$isunknown(o_rb_sel)
   ) else $error("settings_regs: readback select is unknown");

endmodule

//--- tb_checker.sv
// Testbench monitor
// Compares the DUT outputs with the reference model on every falling edge
// and keeps one error count per output

`timescale 1ns/10ps

module tb_checker import radio_pkg::*; (
   input  logic              bus_clk,
   input  logic              i_rst_n,
   input  logic [DATA_W-1:0] i_tx,
   input  logic [DATA_W-1:0] i_exp_tx,
   input  logic [TIME_W-1:0] i_rb_data,
   input  logic [TIME_W-1:0] i_exp_rb_data,
   input  logic [TIME_W-1:0] i_vita_time,
   input  logic [TIME_W-1:0] i_exp_vita_time,
   output int                o_err_tx,
   output int                o_err_rb,
   output int                o_err_time
);

   initial begin
      o_err_tx   = 0;
      o_err_rb   = 0;
      o_err_time = 0;
   end

   //////////////////////////////
   // Per-cycle compare
   //////////////////////////////

   // Falling edge, halfway between register updates
   always @(negedge bus_clk) begin
      if (i_rst_n) begin
         if (i_tx !== i_exp_tx) begin
            o_err_tx = o_err_tx + 1;
            $display("MISMATCH at %0t ns: o_tx is %h, model expects %h",
                     $time, i_tx, i_exp_tx);
         end
         if (i_rb_data !== i_exp_rb_data) begin
            o_err_rb = o_err_rb + 1;
            $display("MISMATCH at %0t ns: o_rb_data is %h, model expects %h",
                     $time, i_rb_data, i_exp_rb_data);
         end
         if (i_vita_time !== i_exp_vita_time) begin
            o_err_time = o_err_time + 1;
            $display("MISMATCH at %0t ns: o_vita_time is %h, model expects %h",
                     $time, i_vita_time, i_exp_vita_time);
         end
      end
   end

endmodule

//--- tb_clkgen.sv
// Testbench clock and reset generator
// 100 ns bus clock, reset held low for the first 16 cycles

`timescale 1ns/10ps

module tb_clkgen #(
   parameter int RST_CYCLES = 16
) (
   output logic bus_clk,
   output logic o_rst_n
);

   initial begin
      bus_clk = 1'b0;
      forever #50 bus_clk = ~bus_clk;
   end

   initial begin
      o_rst_n = 1'b0;
      repeat (RST_CYCLES) @(posedge bus_clk);
      o_rst_n <= 1'b1;                       // Released on a rising edge
   end

endmodule

//--- tb_radio.sv
// Radio core testbench
// Random setting writes, rx words and pps pulses from an LFSR, with a
// cycle-accurate reference model compared against the DUT by tb_checker

`timescale 1ns/10ps

module tb_radio import radio_pkg::*; ();

   localparam int TIME_BASE    = SR_TIME_DEFAULT;
   localparam int RST_WAIT_MAX = 40;
   localparam int PPS_WAIT_MAX = 200;
   localparam logic [ADDR_W-1:0] TIME_HI   = ADDR_W'(TIME_BASE);
   localparam logic [ADDR_W-1:0] TIME_LO   = ADDR_W'(TIME_BASE + 1);
   localparam logic [ADDR_W-1:0] TIME_CTRL = ADDR_W'(TIME_BASE + 2);

   logic              bus_clk;
   logic              rst_n;
   logic              set_stb;
   logic [ADDR_W-1:0] set_addr;
   logic [DATA_W-1:0] set_data;
   logic [DATA_W-1:0] rx;
   logic              pps;
   logic [DATA_W-1:0] tx;
   rb_word_t          rb_data;
   logic [TIME_W-1:0] vita_time;

   logic [31:0]       lfsr_state = 32'hab3;
   logic              pps_random;            // Random pps while set
   int                timeouts   = 0;
   int                err_tx;
   int                err_rb;
   int                err_time;

   // Reference model state
   logic [DATA_W-1:0]   m_test, m_idle, m_cw0, m_tx;
   logic [15:0]         m_cw1, m_cw2;
   logic [RB_SEL_W-1:0] m_rb_sel;
   logic                m_run, m_clr, m_armed, m_pps_prev;
   logic [1:0]          m_phase;
   logic [TIME_W-1:0]   m_pend, m_time, m_lastpps, m_rb;

   tb_clkgen u_clkgen (.bus_clk (bus_clk), .o_rst_n (rst_n));

   radio_core #(.TIME_BASE (TIME_BASE)) dut (
      .bus_clk    (bus_clk),  .i_rst_n    (rst_n),
      .i_set_stb  (set_stb),  .i_set_addr (set_addr), .i_set_data (set_data),
      .i_rx       (rx),       .i_pps      (pps),
      .o_tx       (tx),       .o_rb_data  (rb_data),  .o_vita_time (vita_time)
   );

   tb_checker u_checker (
      .bus_clk     (bus_clk),   .i_rst_n         (rst_n),
      .i_tx        (tx),        .i_exp_tx        (m_tx),
      .i_rb_data   (rb_data),   .i_exp_rb_data   (m_rb),
      .i_vita_time (vita_time), .i_exp_vita_time (m_time),
      .o_err_tx    (err_tx),    .o_err_rb        (err_rb),  .o_err_time (err_time)
   );

   //////////////////////////////
   // Random numbers
   //////////////////////////////
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);   // x^32+x^22+x^2+x+1
   endfunction

   function logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_step(lfsr_state);
         v = {v[30:0], lfsr_state[0]};
      end
      return v;
   endfunction

   //////////////////////////////
   // Reference model
   //////////////////////////////
   function automatic logic [DATA_W-1:0] expected_word(input logic [1:0] ph);
      case (ph)
         2'd1:    return {m_cw1, m_cw2};
         2'd2:    return {m_cw2, m_cw1};
         default: return m_cw0;
      endcase
   endfunction

   function automatic logic [TIME_W-1:0] expected_readback();
      case (m_rb_sel)
         RB_TEST:    return {32'd0, m_test};
         RB_TIME:    return m_time;
         RB_LASTPPS: return m_lastpps;
         RB_TXRX:    return {m_tx, rx};
         RB_STATUS:  return {61'd0, m_run, m_phase};
         default:    return '0;
      endcase
   endfunction

   always @(posedge bus_clk) begin : ref_model
      logic pps_rise;
      logic ctrl_wr;
      pps_rise = pps && !m_pps_prev;
      ctrl_wr  = set_stb && (set_addr == TIME_CTRL);
      if (!rst_n) begin
         {m_test, m_idle, m_cw0, m_tx, m_cw1, m_cw2, m_rb_sel} <= '0;
         {m_run, m_clr, m_armed, m_pps_prev, m_phase} <= '0;
         {m_pend, m_time, m_lastpps, m_rb} <= '0;
      end else begin
         m_rb       <= expected_readback();
         m_tx       <= m_run ? expected_word(m_phase) : m_idle;
         m_phase    <= (!m_run || m_clr) ? 2'd0 : 2'((m_phase + 1) % 3);
         m_pps_prev <= pps;
         if (set_stb) begin
            case (set_addr)
               SR_TEST:       m_test   <= set_data;
               SR_CODEC_IDLE: m_idle   <= set_data;
               SR_READBACK:   m_rb_sel <= set_data[RB_SEL_W-1:0];
               SR_LLR_REG0:   m_cw0    <= set_data;
               SR_LLR_REG1:   m_cw1    <= set_data[15:0];
               SR_LLR_REG2:   m_cw2    <= set_data[15:0];
               TIME_HI:       m_pend[63:32] <= set_data;
               TIME_LO:       m_pend[31:0]  <= set_data;
               SR_CNTRL: begin
                  m_run <= set_data[CNTRL_RUN_BIT];
                  m_clr <= set_data[CNTRL_CLR_BIT];
               end
               default: ;
            endcase
         end
         // Load now beats an armed pps load
         if (ctrl_wr && set_data[TIME_LOAD_NOW_BIT])
            m_time <= m_pend;
         else if (pps_rise && m_armed)
            m_time <= m_pend;
         else
            m_time <= m_time + 64'd1;
         if (pps_rise) begin
            m_lastpps <= m_time;
            m_armed   <= 1'b0;
         end else if (ctrl_wr && set_data[TIME_LOAD_PPS_BIT]) begin
            m_armed <= 1'b1;
         end
      end
   end

   //////////////////////////////
   // Stimulus tasks
   //////////////////////////////
   task step_cycle();
      logic [31:0] r;
      @(posedge bus_clk);
      r = pps_random ? rand_bits(1) : 32'd0;
      rx  <= rand_bits(DATA_W);
      pps <= r[0];
   endtask

   task idle_cycles(input int n);
      repeat (n) step_cycle();
   endtask

   task write_reg(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
      step_cycle();
      set_stb  <= 1'b1;
      set_addr <= addr;
      set_data <= data;
      step_cycle();
      set_stb  <= 1'b0;
   endtask

   task wait_reset();
      int n;
      n = 0;
      while (!rst_n && n < RST_WAIT_MAX) begin
         @(posedge bus_clk);
         n++;
      end
      if (!rst_n) begin
         $display("Timeout: reset still asserted after %0d cycles", RST_WAIT_MAX);
         timeouts++;
      end
   endtask

   task wait_pps_load();
      int n;
      n = 0;
      step_cycle();                          // Arm from the write edge shows up here
      while (m_armed && n < PPS_WAIT_MAX) begin
         step_cycle();
         n++;
      end
      if (m_armed) begin
         $display("Timeout: no pps edge consumed the armed load in %0d cycles",
                  PPS_WAIT_MAX);
         timeouts++;
      end
   endtask

   //////////////////////////////
   // Test sequence
   //////////////////////////////
   initial begin
      set_stb    = 1'b0;
      set_addr   = '0;
      set_data   = '0;
      rx         = '0;
      pps        = 1'b0;
      pps_random = 1'b0;
      wait_reset();

      // Test word readback
      write_reg(SR_READBACK, RB_TEST);
      write_reg(SR_TEST, rand_bits(DATA_W));
      idle_cycles(4);

      // Idle word on TX while stopped
      write_reg(SR_CODEC_IDLE, rand_bits(DATA_W));
      idle_cycles(3);
      write_reg(SR_CODEC_IDLE, rand_bits(DATA_W));
      idle_cycles(3);

      // Codeword phases, clear restarts at word 0
      write_reg(SR_LLR_REG0, rand_bits(DATA_W));
      write_reg(SR_LLR_REG1, rand_bits(DATA_W));
      write_reg(SR_LLR_REG2, rand_bits(DATA_W));
      write_reg(SR_READBACK, RB_STATUS);
      write_reg(SR_CNTRL, 32'h2);
      idle_cycles(10);
      write_reg(SR_CNTRL, 32'h3);
      idle_cycles(3);
      write_reg(SR_CNTRL, 32'h2);
      idle_cycles(7);
      write_reg(SR_CNTRL, 32'h0);

      // Immediate time load
      write_reg(SR_READBACK, RB_TIME);
      write_reg(TIME_HI, rand_bits(DATA_W));
      write_reg(TIME_LO, rand_bits(DATA_W));
      write_reg(TIME_CTRL, 32'h1);
      idle_cycles(8);

      // Armed load on pps, then a second capture without reload
      write_reg(TIME_HI, rand_bits(DATA_W));
      write_reg(TIME_LO, rand_bits(DATA_W));
      write_reg(SR_READBACK, RB_LASTPPS);
      write_reg(TIME_CTRL, 32'h2);
      pps_random = 1'b1;
      wait_pps_load();
      idle_cycles(12);
      pps_random = 1'b0;
      idle_cycles(4);

      // TX and RX readback, then the unused selects
      write_reg(SR_CNTRL, 32'h2);
      write_reg(SR_READBACK, RB_TXRX);
      idle_cycles(8);
      for (int sel = 5; sel < 8; sel++) begin
         write_reg(SR_READBACK, sel);
         idle_cycles(3);
      end
      idle_cycles(2);

      $display("Errors: tx %0d, readback %0d, time %0d, timeouts %0d",
               err_tx, err_rb, err_time, timeouts);
      if (err_tx + err_rb + err_time + timeouts == 0)
         $display("*** TEST PASSED ***");
      else
         $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

//--- timekeeper.sv
// Radio timekeeper
// Free-running time counter with immediate load, load on the next pps
// edge, and capture of the time at the last pps edge

`timescale 1ns/10ps

module timekeeper import radio_pkg::*; #(
   parameter int TIME_BASE = SR_TIME_DEFAULT
) (
   input  logic              bus_clk,
   input  logic              i_rst_n,
   input  logic              i_set_stb,
   input  logic [ADDR_W-1:0] i_set_addr,
   input  logic [DATA_W-1:0] i_set_data,
   input  logic              i_pps,
   output logic [TIME_W-1:0] o_vita_time,
   output logic [TIME_W-1:0] o_lastpps
);

   localparam logic [ADDR_W-1:0] ADDR_HI   = ADDR_W'(TIME_BASE);
   localparam logic [ADDR_W-1:0] ADDR_LO   = ADDR_W'(TIME_BASE + 1);
   localparam logic [ADDR_W-1:0] ADDR_CTRL = ADDR_W'(TIME_BASE + 2);

   logic [TIME_W-1:0] pend_time;             // Value for the next load
   logic              pps_d;
   logic              armed;
   logic              pps_edge;
   logic              ctrl_wr;
   logic              load_now;

   assign pps_edge = i_pps & ~pps_d;
   assign ctrl_wr  = i_set_stb && (i_set_addr == ADDR_CTRL);
   assign load_now = ctrl_wr && i_set_data[TIME_LOAD_NOW_BIT];

   //////////////////////////////
   // Pending time and pps arm
   //////////////////////////////
   always_ff @(posedge bus_clk) begin
      if (!i_rst_n) begin
         pend_time <= '0;
         pps_d     <= 1'b0;
         armed     <= 1'b0;
      end else begin
         pps_d <= i_pps;
         if (i_set_stb && (i_set_addr == ADDR_HI))
            pend_time[TIME_W-1:DATA_W] <= i_set_data;
         if (i_set_stb && (i_set_addr == ADDR_LO))
            pend_time[DATA_W-1:0] <= i_set_data;
         // A pps edge always consumes the arm
         if (pps_edge)
            armed <= 1'b0;
         else if (ctrl_wr && i_set_data[TIME_LOAD_PPS_BIT])
            armed <= 1'b1;
      end
   end

   //////////////////////////////
   // Time counter
   //////////////////////////////
   always_ff @(posedge bus_clk) begin
      if (!i_rst_n) begin
         o_vita_time <= '0;
         o_lastpps   <= '0;
      end else begin
         if (load_now)
            o_vita_time <= pend_time;         // Immediate load wins
         else if (pps_edge && armed)
            o_vita_time <= pend_time;
         else
            o_vita_time <= o_vita_time + 1'b1;

         if (pps_edge)
            o_lastpps <= o_vita_time;         // Time before this edge
      end
   end

   a_arm_clears: assert property (
      @(posedge bus_clk) disable iff (!i_rst_n)
      pps_edge |=> !armed
   ) else $error("timekeeper: pps load still armed after pps edge");

endmodule
